/* verilog.f */
+incdir+.
branchPred_pkg.sv
branchCondDecode.sv
branchTargetTable.sv
patternHistoryTable.sv
predictSequencer.sv
branchPredictor.sv
branchPredictor_assertions.sv
branchPredictor_tb.sv

/* Bender.yml */
package:
  name: branch_predictor

sources:
  - include_dirs:
      - .
    files:
      - branchPred_pkg.sv
      - branchCondDecode.sv
      - branchTargetTable.sv
      - patternHistoryTable.sv
      - predictSequencer.sv
      - branchPredictor.sv
  - target: test
    include_dirs:
      - .
    files:
      - branchPredictor_assertions.sv
      - branchPredictor_tb.sv

/* branchPredictor_tb.sv */
`timescale 1ns/1ps

module branchPredictor_tb;
    import branchPredictor_pkg::*;

    // One branch with its lookup, idle gap, resolve and expected outputs
    typedef struct packed {
        logic [7:0] address;
        logic [4:0] jumpCode;
        logic [3:0] flags;
        logic [3:0] gap;
        logic       expJump;
        logic       expCorrect;
    } stimRow_t;

    localparam int ResetCycles = 5;
    localparam int Margin      = 20;

    logic       clk = 1'b0;
    logic       resetn;
    logic       enable;
    branchReq_t req;
    logic       jumpTaken;
    logic       predCorrect;

    stimRow_t rows [$];
    logic     lastCorrect;
    int       cycleCount   = 0;
    int       timeoutLimit = 100000;

    branchPredictor branchPredictor_inst (
        .clk         (clk),
        .resetn      (resetn),
        .enable      (enable),
        .req         (req),
        .jumpTaken   (jumpTaken),
        .predCorrect (predCorrect)
    );

    bind branchPredictor branchPredictor_assertions assertions_inst (
        .clk         (clk),
        .resetn      (resetn),
        .enable      (enable),
        .phase       (phase),
        .jumpTaken   (jumpTaken),
        .predCorrect (predCorrect)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutLimit) begin
            $display("Timeout: the test did not finish within %0d cycles", timeoutLimit);
            $display("=== FAIL ===");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    always @(posedge clk) begin
        if (branchPredictor_inst.assertions_inst.assertFails != 0) begin
            $display("A protocol assertion failed");
            $display("=== FAIL ===");
            $fatal(1, "Protocol assertion failed");
        end
    end

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %0d, actual %0d", testName, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic addRow(input logic [7:0] address, input logic [4:0] jumpCode,
                          input logic [3:0] flags, input logic [3:0] gap,
                          input logic expJump, input logic expCorrect);
        rows.push_back({address, jumpCode, flags, gap, expJump, expCorrect});
    endtask

    // Flags are {carry, negative, overflow, zero}
    task automatic buildTable();
        // Cold miss predicts taken and JZ1 with zero set is taken
        addRow(8'h10, JZ1, 4'b0001, 4'd0, 1'b1, 1'b1);
        // Training 0x20 toward not taken and back up from the bottom
        addRow(8'h20, JZ1, 4'b0000, 4'd1, 1'b1, 1'b0);
        addRow(8'h20, JZ1, 4'b0000, 4'd0, 1'b0, 1'b1);
        addRow(8'h20, JZ1, 4'b1110, 4'd2, 1'b0, 1'b1);
        addRow(8'h20, JZ1, 4'b0001, 4'd0, 1'b0, 1'b0);
        addRow(8'h20, JZ1, 4'b0001, 4'd3, 1'b0, 1'b0);
        addRow(8'h20, JZ1, 4'b0000, 4'd0, 1'b1, 1'b0);
        // Every code with its flag set and clear while 0x10 stays on the taken side
        addRow(8'h10, JC1, 4'b1000, 4'd0, 1'b1, 1'b1);
        addRow(8'h10, JC1, 4'b0111, 4'd1, 1'b1, 1'b0);
        addRow(8'h10, JN1, 4'b0100, 4'd0, 1'b1, 1'b1);
        addRow(8'h10, JN1, 4'b1011, 4'd2, 1'b1, 1'b0);
        addRow(8'h10, JV1, 4'b0010, 4'd0, 1'b1, 1'b1);
        addRow(8'h10, JV1, 4'b1101, 4'd1, 1'b1, 1'b0);
        addRow(8'h10, JZ1, 4'b0001, 4'd0, 1'b1, 1'b1);
        addRow(8'h10, JZ1, 4'b1110, 4'd0, 1'b1, 1'b0);
        addRow(8'h10, JC0, 4'b0111, 4'd3, 1'b1, 1'b1);
        addRow(8'h10, JC0, 4'b1000, 4'd0, 1'b1, 1'b0);
        addRow(8'h10, JN0, 4'b1011, 4'd1, 1'b1, 1'b1);
        addRow(8'h10, JN0, 4'b0100, 4'd0, 1'b1, 1'b0);
        addRow(8'h10, JV0, 4'b1101, 4'd0, 1'b1, 1'b1);
        addRow(8'h10, JV0, 4'b0010, 4'd2, 1'b1, 1'b0);
        addRow(8'h10, JZ0, 4'b1110, 4'd0, 1'b1, 1'b1);
        addRow(8'h10, JZ0, 4'b0001, 4'd1, 1'b1, 1'b0);
        // A code that is not a conditional jump leaves the counter alone and is never correct
        addRow(8'h10, 5'b00000, 4'b1111, 4'd2, 1'b1, 1'b0);
        addRow(8'h20, 5'b00000, 4'b0000, 4'd0, 1'b0, 1'b0);
        addRow(8'h10, JZ1, 4'b0001, 4'd1, 1'b1, 1'b1);
        addRow(8'h20, JZ1, 4'b0001, 4'd0, 1'b0, 1'b0);
        // The ninth of nine new tags from slot 2 on evicts 0x30
        addRow(8'h30, JZ1, 4'b0000, 4'd0, 1'b1, 1'b0);
        addRow(8'hFF, JZ1, 4'b0000, 4'd1, 1'b1, 1'b0);
        addRow(8'h41, JZ1, 4'b0000, 4'd0, 1'b1, 1'b0);
        addRow(8'h52, JZ1, 4'b0000, 4'd0, 1'b1, 1'b0);
        addRow(8'h63, JZ1, 4'b0000, 4'd0, 1'b1, 1'b0);
        addRow(8'h74, JZ1, 4'b0000, 4'd0, 1'b1, 1'b0);
        addRow(8'h85, JZ1, 4'b0000, 4'd0, 1'b1, 1'b0);
        addRow(8'h96, JZ1, 4'b0000, 4'd0, 1'b1, 1'b0);
        addRow(8'hA7, JZ1, 4'b0000, 4'd0, 1'b1, 1'b0);
        // 0x30 misses again and takes the slot that held 0xFF
        addRow(8'h30, JZ1, 4'b0001, 4'd0, 1'b1, 1'b1);
        addRow(8'h41, JZ1, 4'b0000, 4'd2, 1'b0, 1'b1);
        addRow(8'hA7, JZ1, 4'b0001, 4'd0, 1'b0, 1'b0);
        // Restarted at weak taken, so 0x30 still predicts taken after one not-taken step
        addRow(8'h30, JZ1, 4'b0000, 4'd1, 1'b1, 1'b0);
        addRow(8'h30, JZ1, 4'b0000, 4'd0, 1'b1, 1'b0);
    endtask

    function automatic int runLength();
        int total;
        total = ResetCycles + Margin;
        foreach (rows[i]) begin
            total = total + 4 + rows[i].gap;
        end
        return total;
    endfunction

    task automatic driveRequest(input logic en, input logic [7:0] address,
                                input logic [4:0] jumpCode, input logic [3:0] flags);
        enable          = en;
        req.address     = address;
        req.jumpType    = jumpType_t'(jumpCode);
        req.flags       = flags;
    endtask

    task automatic runRow(input int idx);
        stimRow_t row;
        row = rows[idx];
        driveRequest(1'b1, row.address, row.jumpCode, row.flags);
        @(posedge clk);
        #1;
        checkValue($sformatf("row %0d lookup jumpTaken", idx), row.expJump, jumpTaken);
        checkValue($sformatf("row %0d lookup predCorrect", idx), lastCorrect, predCorrect);
        // Inverted flags on the bus while enable is low must be ignored
        repeat (row.gap) begin
            driveRequest(1'b0, ~row.address, row.jumpCode, ~row.flags);
            @(posedge clk);
            #1;
            checkValue($sformatf("row %0d idle jumpTaken", idx), row.expJump, jumpTaken);
            checkValue($sformatf("row %0d idle predCorrect", idx), lastCorrect, predCorrect);
        end
        driveRequest(1'b1, row.address, row.jumpCode, row.flags);
        @(posedge clk);
        #1;
        checkValue($sformatf("row %0d resolve predCorrect", idx), row.expCorrect, predCorrect);
        checkValue($sformatf("row %0d resolve jumpTaken", idx), row.expJump, jumpTaken);
        lastCorrect = row.expCorrect;
        driveRequest(1'b0, 8'h00, 5'b00000, 4'b0000);
    endtask

    initial begin
        resetn      = 1'b0;
        enable      = 1'b0;
        req         = '0;
        lastCorrect = 1'b0;
        buildTable();
        timeoutLimit = runLength();

        repeat (ResetCycles) @(posedge clk);
        #1;
        resetn = 1'b1;
        checkValue("reset jumpTaken", 0, jumpTaken);
        checkValue("reset predCorrect", 0, predCorrect);

        for (int i = 0; i < rows.size(); i++) begin
            runRow(i);
        end

        // A couple of idle edges so the last assertion attempts complete
        repeat (2) @(posedge clk);
        #1;
        if (branchPredictor_inst.assertions_inst.assertFails == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Assertion failures: %0d", branchPredictor_inst.assertions_inst.assertFails);
            $display("=== FAIL ===");
            $fatal(1, "Protocol assertions failed");
        end
    end

endmodule

/* branchPredictor_assertions.sv */
`timescale 1ns/1ps

module branchPredictor_assertions (
    input logic clk,
    input logic resetn,
    input logic enable,
    input logic phase,
    input logic jumpTaken,
    input logic predCorrect
);

    int assertFails = 0;

    property resetClearsOutputs;
        @(posedge clk) !resetn |=> (!jumpTaken && !predCorrect);
    endproperty

    // Nothing moves on a cycle without enable
    property idleHoldsState;
        @(posedge clk) (resetn && !enable)
            |=> ($stable(jumpTaken) && $stable(predCorrect) && $stable(phase));
    endproperty

    // phase high with enable is the edge that closes a resolve
    property correctOnlyOnResolve;
        @(posedge clk) (resetn && !(enable && phase)) |=> $stable(predCorrect);
    endproperty

    resetClearsCheck: assert property (resetClearsOutputs) else begin
        $error("Outputs not cleared after reset");
        assertFails++;
    end

    idleHoldsCheck: assert property (idleHoldsState) else begin
        $error("State changed while enable was low");
        assertFails++;
    end

    correctOnlyCheck: assert property (correctOnlyOnResolve) else begin
        $error("predCorrect changed outside a resolve edge");
        assertFails++;
    end

endmodule

/* branchPredictor.sv */
`timescale 1ns/1ps

`include "branchPred_consts.svh"

module branchPredictor (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            enable,
    input  branchPredictor_pkg::branchReq_t req,
    output logic                            jumpTaken,
    output logic                            predCorrect
);

    logic                            hit;
    logic [`BP_INDEX_W-1:0]          hitIndex;
    logic [`BP_INDEX_W-1:0]          allocIndex;
    logic                            allocate;
    logic [`BP_INDEX_W-1:0]          readIndex;
    branchPredictor_pkg::predState_t readState;
    logic                            writeEn;
    logic [`BP_INDEX_W-1:0]          writeIndex;
    logic                            writeInit;
    logic                            condValid;
    logic                            actualTaken;
    logic                            phase;

    branchCondDecode condDecode_inst (
        .jumpType    (req.jumpType),
        .flags       (req.flags),
        .condValid   (condValid),
        .actualTaken (actualTaken)
    );

    branchTargetTable targetTable_inst (
        .clk        (clk),
        .resetn     (resetn),
        .address    (req.address),
        .allocate   (allocate),
        .hit        (hit),
        .hitIndex   (hitIndex),
        .allocIndex (allocIndex)
    );

    patternHistoryTable historyTable_inst (
        .clk        (clk),
        .resetn     (resetn),
        .readIndex  (readIndex),
        .readState  (readState),
        .writeEn    (writeEn),
        .writeIndex (writeIndex),
        .writeInit  (writeInit),
        .outcome    (actualTaken)
    );

    predictSequencer sequencer_inst (
        .clk         (clk),
        .resetn      (resetn),
        .enable      (enable),
        .hit         (hit),
        .hitIndex    (hitIndex),
        .allocIndex  (allocIndex),
        .readState   (readState),
        .condValid   (condValid),
        .actualTaken (actualTaken),
        .allocate    (allocate),
        .readIndex   (readIndex),
        .writeEn     (writeEn),
        .writeIndex  (writeIndex),
        .writeInit   (writeInit),
        .phase       (phase),
        .jumpTaken   (jumpTaken),
        .predCorrect (predCorrect)
    );

endmodule

/* predictSequencer.sv */
`timescale 1ns/1ps

`include "branchPred_consts.svh"

module predictSequencer (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            enable,
    input  logic                            hit,
    input  logic [`BP_INDEX_W-1:0]          hitIndex,
    input  logic [`BP_INDEX_W-1:0]          allocIndex,
    input  branchPredictor_pkg::predState_t readState,
    input  logic                            condValid,
    input  logic                            actualTaken,
    output logic                            allocate,
    output logic [`BP_INDEX_W-1:0]          readIndex,
    output logic                            writeEn,
    output logic [`BP_INDEX_W-1:0]          writeIndex,
    output logic                            writeInit,
    output logic                            phase,
    output logic                            jumpTaken,
    output logic                            predCorrect
);
    import branchPredictor_pkg::*;

    // phase 0 is lookup, 1 is resolve
    logic                   lookup;
    logic [`BP_INDEX_W-1:0] entryIdx;
    logic                   hitPredTaken;

    assign lookup = !phase;

    assign readIndex    = hitIndex;
    assign hitPredTaken = (readState == strongTaken) || (readState == weakTaken);

    // Lookup miss claims the FIFO slot and seeds its counter
    assign allocate   = enable && lookup && !hit;
    assign writeInit  = lookup;
    assign writeIndex = lookup ? allocIndex : entryIdx;

    // Resolve only trains on a real conditional jump
    assign writeEn = enable && (lookup ? !hit : condValid);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase       <= 1'b0;
            jumpTaken   <= 1'b0;
            predCorrect <= 1'b0;
        end else if (enable) begin
            phase <= ~phase;
            if (lookup) begin
                // Unknown branches are guessed taken
                jumpTaken <= hit ? hitPredTaken : 1'b1;
            end else begin
                predCorrect <= condValid && (jumpTaken == actualTaken);
            end
        end
    end

    // Entry under resolution, held across idle cycles
    always_ff @(posedge clk) begin
        if (enable && lookup) begin
            entryIdx <= hit ? hitIndex : allocIndex;
        end
    end

endmodule

/* patternHistoryTable.sv */
`timescale 1ns/1ps

`include "branchPred_consts.svh"

module patternHistoryTable (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic [`BP_INDEX_W-1:0]             readIndex,
    output branchPredictor_pkg::predState_t    readState,
    input  logic                               writeEn,
    input  logic [`BP_INDEX_W-1:0]             writeIndex,
    input  logic                               writeInit,
    input  logic                               outcome
);
    import branchPredictor_pkg::*;

    predState_t states [`BP_TABLE_DEPTH];
    predState_t nextState;

    // One step toward strongTaken or strongNotTaken, saturating at both ends
    function automatic predState_t stepState(input predState_t cur, input logic taken);
        predState_t res;
        res = cur;
        case (cur)
            strongTaken:    res = taken ? strongTaken : weakTaken;
            weakTaken:      res = taken ? strongTaken : weakNotTaken;
            weakNotTaken:   res = taken ? weakTaken : strongNotTaken;
            strongNotTaken: res = taken ? weakNotTaken : strongNotTaken;
            default:        res = weakTaken;
        endcase
        return res;
    endfunction

    assign readState = states[readIndex];
    assign nextState = stepState(states[writeIndex], outcome);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `BP_TABLE_DEPTH; i++) begin
                states[i] <= weakTaken;
            end
        end else if (writeEn) begin
            // Fresh allocation starts over at weak taken
            if (writeInit) begin
                states[writeIndex] <= weakTaken;
            end else begin
                states[writeIndex] <= nextState;
            end
        end
    end

endmodule

/* branchTargetTable.sv */
`timescale 1ns/1ps

`include "branchPred_consts.svh"

module branchTargetTable (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [`BP_ADDR_W-1:0]  address,
    input  logic                   allocate,
    output logic                   hit,
    output logic [`BP_INDEX_W-1:0] hitIndex,
    output logic [`BP_INDEX_W-1:0] allocIndex
);

    logic [`BP_ADDR_W-1:0]     tags [`BP_TABLE_DEPTH];
    logic [`BP_TABLE_DEPTH-1:0] valid;
    logic [`BP_INDEX_W-1:0]    allocPtr;

    // Parallel tag compare, a later match overrides an earlier one
    always_comb begin
        hit      = 1'b0;
        hitIndex = '0;
        for (int i = 0; i < `BP_TABLE_DEPTH; i++) begin
            if (valid[i] && (tags[i] == address)) begin
                hit      = 1'b1;
                hitIndex = i[`BP_INDEX_W-1:0];
            end
        end
    end

    assign allocIndex = allocPtr;

    // Valid bits and FIFO pointer
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid    <= '0;
            allocPtr <= '0;
        end else if (allocate) begin
            valid[allocPtr] <= 1'b1;
            // Wraps back to entry 0 after the last one
            allocPtr        <= allocPtr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (allocate) begin
            tags[allocPtr] <= address;
        end
    end

endmodule

/* branchCondDecode.sv */
`timescale 1ns/1ps

`include "branchPred_consts.svh"

module branchCondDecode (
    input  branchPredictor_pkg::jumpType_t    jumpType,
    input  branchPredictor_pkg::statusFlags_t flags,
    output logic                              condValid,
    output logic                              actualTaken
);
    import branchPredictor_pkg::*;

    localparam int SelW = $clog2(`BP_FLAG_W);

    // Bit positions inside the flag word, carry is the MSB
    localparam logic [SelW-1:0] CarryBit    = 3;
    localparam logic [SelW-1:0] NegativeBit = 2;
    localparam logic [SelW-1:0] OverflowBit = 1;
    localparam logic [SelW-1:0] ZeroBit     = 0;

    logic [`BP_FLAG_W-1:0] flagVec;
    logic [SelW-1:0]       flagSel;
    logic                  wantSet;

    assign flagVec = flags;

    // Each code picks one flag and the level that makes the jump go
    always_comb begin
        condValid = 1'b1;
        flagSel   = ZeroBit;
        wantSet   = 1'b1;
        case (jumpType)
            JC1: {flagSel, wantSet} = {CarryBit, 1'b1};
            JN1: {flagSel, wantSet} = {NegativeBit, 1'b1};
            JV1: {flagSel, wantSet} = {OverflowBit, 1'b1};
            JZ1: {flagSel, wantSet} = {ZeroBit, 1'b1};
            JC0: {flagSel, wantSet} = {CarryBit, 1'b0};
            JN0: {flagSel, wantSet} = {NegativeBit, 1'b0};
            JV0: {flagSel, wantSet} = {OverflowBit, 1'b0};
            JZ0: {flagSel, wantSet} = {ZeroBit, 1'b0};
            default: begin
                // Not a conditional jump
                condValid = 1'b0;
            end
        endcase
    end

    assign actualTaken = condValid && (flagVec[flagSel] == wantSet);

endmodule

/* branchPred_pkg.sv */
package branchPredictor_pkg;

    `include "branchPred_consts.svh"

    // Upper bit clear means the entry predicts taken
    typedef enum logic [1:0] {
        strongTaken    = 2'b00,
        weakTaken      = 2'b01,
        weakNotTaken   = 2'b10,
        strongNotTaken = 2'b11
    } predState_t;

    typedef enum logic [`BP_JTYPE_W-1:0] {
        JC1 = 5'b10000,
        JN1 = 5'b01000,
        JV1 = 5'b00100,
        JZ1 = 5'b00010,
        JC0 = 5'b01110,
        JN0 = 5'b10110,
        JV0 = 5'b11010,
        JZ0 = 5'b11100
    } jumpType_t;

    typedef struct packed {
        logic carry;
        logic negative;
        logic overflow;
        logic zero;
    } statusFlags_t;

    typedef struct packed {
        logic [`BP_ADDR_W-1:0] address;
        jumpType_t             jumpType;
        statusFlags_t          flags;
    } branchReq_t;

endpackage

/* branchPred_consts.svh */
`ifndef BRANCH_PRED_CONSTS_SVH
`define BRANCH_PRED_CONSTS_SVH

// Branch target table geometry
`define BP_TABLE_DEPTH 8
`define BP_INDEX_W 3

// Only the low byte of the branch address is kept as tag
`define BP_ADDR_W 8

// Conditional jump code as issued by the CPU decoder
`define BP_JTYPE_W 5

// Carry, negative, overflow and zero
`define BP_FLAG_W 4

`endif
